// ==== verilog/wrb_pkg.sv ====
/*
 * Writeback subsystem package
 * Shared widths, select and divide encodings, FSM states and stage structs
 */

package wrb_pkg;

    // Machine word width
    parameter int XLEN = 32;

    // Register value and register index
    typedef logic [XLEN-1:0] data_t;
    typedef logic [4:0]      reg_addr_t;

    // Source of the value written to rd
    typedef enum logic [2:0] {
        RD_WRB_ALU    = 3'd0,
        RD_WRB_INC_PC = 3'd1,
        RD_WRB_DMEM   = 3'd2,
        RD_WRB_CSR    = 3'd3,
        RD_WRB_D_ALU  = 3'd4
    } rd_wrb_sel_e;

    // M-extension divide operations
    typedef enum logic [1:0] {
        DIV  = 2'd0,
        DIVU = 2'd1,
        REM  = 2'd2,
        REMU = 2'd3
    } div_op_e;

    // Divider FSM
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } div_state_e;

    // LSU/writeback pipe FSM
    typedef enum logic [1:0] {
        EMPTY    = 2'd0,
        WAIT_DIV = 2'd1,
        COMMIT   = 2'd2
    } pipe_state_e;

    // LSU results headed for writeback
    typedef struct packed {
        data_t     alu_result;
        data_t     pc_ff;
        data_t     r_data;
        reg_addr_t rd_addr;
    } lsu2wrb_data_s;

    typedef struct packed {
        rd_wrb_sel_e rd_wrb_sel;
        logic        rd_wr_req;
    } lsu2wrb_ctrl_s;

    typedef struct packed {
        data_t csr_rdata;
    } csr2wrb_data_s;

    // Divide request and result
    typedef struct packed {
        div_op_e op;
        data_t   dividend;
        data_t   divisor;
    } exe2div_s;

    typedef struct packed {
        data_t alu_d_result;
    } div2wrb_s;

    // Register write feedback toward decode
    typedef struct packed {
        data_t     rd_data;
        reg_addr_t rd_addr;
        logic      rd_wr_req;
    } wrb2id_fb_s;

    // Forwarding and hazard info
    typedef struct packed {
        reg_addr_t rd_addr;
        logic      rd_wr_req;
    } wrb2fwd_s;

    typedef struct packed {
        logic      div_pending;
        reg_addr_t rd_addr;
    } pipe2fwd_s;

endpackage : wrb_pkg

// ==== verilog/lsu_wrb_pipe.sv ====
/*
 * LSU/writeback pipeline register
 * Holds one instruction, launches divides and releases the write on commit
 */

`timescale 1ns/1ps

module lsu_wrb_pipe import wrb_pkg::*; (
    input  logic          clk,
    input  logic          reset_i,

    // Incoming instruction stream
    input  logic          in_valid_i,
    output logic          in_ready_o,
    input  lsu2wrb_data_s lsu2wrb_data_i,
    input  lsu2wrb_ctrl_s lsu2wrb_ctrl_i,
    input  csr2wrb_data_s csr2wrb_data_i,
    input  exe2div_s      exe2div_i,

    // Divider handshake
    output logic          div_start_o,
    output exe2div_s      exe2div_o,
    input  logic          div_done_i,

    // Held entry toward writeback
    output lsu2wrb_data_s lsu2wrb_data_o,
    output lsu2wrb_ctrl_s lsu2wrb_ctrl_o,
    output csr2wrb_data_s csr2wrb_data_o,

    // Pending divide info for the hazard check
    output pipe2fwd_s     pipe2fwd_o
);

    pipe_state_e   state_q, state_d;
    logic          rdy_q;
    logic          accept;
    logic          in_is_div;
    logic          held_is_div;

    lsu2wrb_data_s data_q;
    lsu2wrb_ctrl_s ctrl_q;
    csr2wrb_data_s csr_q;

    assign accept    = in_valid_i && rdy_q;
    assign in_is_div = (lsu2wrb_ctrl_i.rd_wrb_sel == RD_WRB_D_ALU);

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            EMPTY, COMMIT: begin
                if (accept) begin
                    state_d = in_is_div ? WAIT_DIV : COMMIT;
                end else begin
                    state_d = EMPTY;
                end
            end
            WAIT_DIV: begin
                if (div_done_i) begin
                    state_d = COMMIT;
                end
            end
            default: state_d = EMPTY;
        endcase
    end

    // Ready is registered so it stays low through reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= EMPTY;
            rdy_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            rdy_q   <= (state_d != WAIT_DIV);
        end
    end

    // Entry payload captured on each transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= lsu2wrb_data_i;
            ctrl_q <= lsu2wrb_ctrl_i;
            csr_q  <= csr2wrb_data_i;
        end
    end

    assign in_ready_o = rdy_q;

    // Divider launched in the same cycle the divide entry transfers
    assign div_start_o = accept && in_is_div;
    assign exe2div_o   = exe2div_i;

    // Write request only escapes in the commit cycle
    assign lsu2wrb_data_o           = data_q;
    assign csr2wrb_data_o           = csr_q;
    assign lsu2wrb_ctrl_o.rd_wrb_sel = ctrl_q.rd_wrb_sel;
    assign lsu2wrb_ctrl_o.rd_wr_req  = ctrl_q.rd_wr_req && (state_q == COMMIT);

    // Divide result owed to rd until the commit edge
    assign held_is_div = (ctrl_q.rd_wrb_sel == RD_WRB_D_ALU);
    assign pipe2fwd_o.div_pending = held_is_div && ctrl_q.rd_wr_req &&
                                    ((state_q == WAIT_DIV) || (state_q == COMMIT));
    assign pipe2fwd_o.rd_addr     = data_q.rd_addr;

    // Divider answers only the divide this pipe is waiting on
    a_done_in_wait: assert property (@(posedge clk) disable iff (reset_i)
        div_done_i |-> (state_q == WAIT_DIV))
        else $error("div_done outside WAIT_DIV");

endmodule : lsu_wrb_pipe

// ==== verilog/divider.sv ====
/*
 * Iterative radix-2 restoring divider for DIV, DIVU, REM and REMU
 * Works on magnitudes, then applies sign and divide-by-zero rules
 */

`timescale 1ns/1ps

module divider import wrb_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,

    // Start/done handshake
    input  logic     start_i,
    input  exe2div_s exe2div_i,
    output logic     done_o,
    output div2wrb_s div2wrb_o
);

    // XLEN shift steps plus one fix-up step in RUN
    localparam int CNT_W = $clog2(XLEN + 1);

    div_state_e       state_q, state_d;
    logic [CNT_W-1:0] cnt_q;
    logic             last_step;

    // Operand decode at start
    logic             is_signed;
    logic             dvd_neg;
    logic             dvs_neg;
    data_t            dvd_mag;
    data_t            dvs_mag;

    // One restoring step
    logic [XLEN:0]    rem_shift;
    logic [XLEN:0]    rem_diff;
    data_t            quo_fix;
    data_t            rem_fix;

    // Working registers
    data_t            quo_q;
    data_t            rem_q;
    data_t            dvs_mag_q;
    data_t            dividend_q;
    data_t            result_q;
    logic             quo_neg_q;
    logic             rem_neg_q;
    logic             div_zero_q;
    logic             is_rem_q;

    assign is_signed = (exe2div_i.op == DIV) || (exe2div_i.op == REM);
    assign dvd_neg   = is_signed && exe2div_i.dividend[XLEN-1];
    assign dvs_neg   = is_signed && exe2div_i.divisor[XLEN-1];
    assign dvd_mag   = dvd_neg ? -exe2div_i.dividend : exe2div_i.dividend;
    assign dvs_mag   = dvs_neg ? -exe2div_i.divisor : exe2div_i.divisor;

    // Bring down the next dividend bit and trial subtract
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign rem_diff  = rem_shift - {1'b0, dvs_mag_q};

    // Overflow case needs no special path since negating 2^(XLEN-1) wraps to itself
    assign quo_fix = quo_neg_q ? -quo_q : quo_q;
    assign rem_fix = rem_neg_q ? -rem_q : rem_q;

    assign last_step = (cnt_q == CNT_W'(XLEN));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start_i) state_d = RUN;
            RUN:     if (last_step) state_d = DONE;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == RUN) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                cnt_q <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == IDLE) && start_i) begin
            quo_q      <= dvd_mag;
            rem_q      <= '0;
            dvs_mag_q  <= dvs_mag;
            dividend_q <= exe2div_i.dividend;
            quo_neg_q  <= dvd_neg ^ dvs_neg;
            rem_neg_q  <= dvd_neg;
            div_zero_q <= (exe2div_i.divisor == '0);
            is_rem_q   <= (exe2div_i.op == REM) || (exe2div_i.op == REMU);
        end else if ((state_q == RUN) && !last_step) begin
            // Keep the difference when it did not borrow
            if (!rem_diff[XLEN]) begin
                rem_q <= rem_diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end else if (state_q == RUN) begin
            // Divide by zero gives all ones and the dividend back
            if (div_zero_q) begin
                result_q <= is_rem_q ? dividend_q : '1;
            end else begin
                result_q <= is_rem_q ? rem_fix : quo_fix;
            end
        end
    end

    assign done_o                 = (state_q == DONE);
    assign div2wrb_o.alu_d_result = result_q;

    // Pipe must not start a new divide mid-operation
    a_start_idle: assert property (@(posedge clk) disable iff (reset_i)
        start_i |-> (state_q == IDLE))
        else $error("divider started while busy");

endmodule : divider

// ==== verilog/writeback.sv ====
/*
 * Writeback stage
 * Picks the rd value and builds the feedback and forwarding info
 */

`timescale 1ns/1ps

module writeback import wrb_pkg::*; (
    // Held entry from the LSU pipe
    input  lsu2wrb_data_s lsu2wrb_data_i,
    input  lsu2wrb_ctrl_s lsu2wrb_ctrl_i,
    input  csr2wrb_data_s csr2wrb_data_i,

    // Divider result
    input  div2wrb_s      div2wrb_i,

    // Register write toward decode and regfile
    output wrb2id_fb_s    wrb2id_fb_o,

    // Written value for bypassing
    output data_t         wrb2exe_fb_rd_data_o,

    // Destination info for the forward unit
    output wrb2fwd_s      wrb2fwd_o
);

    data_t rd_data;

    // Destination value select
    always_comb begin
        case (lsu2wrb_ctrl_i.rd_wrb_sel)
            RD_WRB_ALU:    rd_data = lsu2wrb_data_i.alu_result;
            RD_WRB_INC_PC: rd_data = lsu2wrb_data_i.pc_ff;
            RD_WRB_DMEM:   rd_data = lsu2wrb_data_i.r_data;
            RD_WRB_CSR:    rd_data = csr2wrb_data_i.csr_rdata;
            RD_WRB_D_ALU:  rd_data = div2wrb_i.alu_d_result;
            default:       rd_data = '0;
        endcase
    end

    assign wrb2id_fb_o.rd_data   = rd_data;
    assign wrb2id_fb_o.rd_addr   = lsu2wrb_data_i.rd_addr;
    assign wrb2id_fb_o.rd_wr_req = lsu2wrb_ctrl_i.rd_wr_req;

    assign wrb2exe_fb_rd_data_o  = rd_data;

    assign wrb2fwd_o.rd_addr     = lsu2wrb_data_i.rd_addr;
    assign wrb2fwd_o.rd_wr_req   = lsu2wrb_ctrl_i.rd_wr_req;

endmodule : writeback

// ==== verilog/regfile.sv ====
/*
 * Integer register file
 * 32 entries, two asynchronous reads, one synchronous write, x0 tied to zero
 */

`timescale 1ns/1ps

module regfile import wrb_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,

    // Write port from writeback
    input  wrb2id_fb_s wrb2id_fb_i,

    // Read ports
    input  reg_addr_t  rs1_addr_i,
    input  reg_addr_t  rs2_addr_i,
    output data_t      rs1_data_o,
    output data_t      rs2_data_o
);

    localparam int NREGS = 2 ** $bits(reg_addr_t);

    data_t regs_q [NREGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wrb2id_fb_i.rd_wr_req && (wrb2id_fb_i.rd_addr != '0)) begin
            regs_q[wrb2id_fb_i.rd_addr] <= wrb2id_fb_i.rd_data;
        end
    end

    // x0 reads as zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

    // No write ever lands in x0
    a_x0_zero: assert property (@(posedge clk) disable iff (reset_i)
        regs_q[0] == '0)
        else $error("x0 storage changed");

endmodule : regfile

// ==== verilog/forward_stall.sv ====
/*
 * Forward and stall unit for the decode operand reads
 * Bypasses the writeback value and stalls on a pending divide
 */

`timescale 1ns/1ps

module forward_stall import wrb_pkg::*; (
    // Decode operand indices
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,

    // Register file read data
    input  data_t     rf_rs1_data_i,
    input  data_t     rf_rs2_data_i,

    // Writeback destination and value
    input  wrb2fwd_s  wrb2fwd_i,
    input  data_t     wrb_rd_data_i,

    // Outstanding divide
    input  pipe2fwd_s pipe2fwd_i,

    output data_t     rs1_data_o,
    output data_t     rs2_data_o,
    output logic      fwd_stall_o
);

    logic rs1_wrb_hit, rs2_wrb_hit;
    logic rs1_div_hit, rs2_div_hit;

    // Writes to x0 are never forwarded
    assign rs1_wrb_hit = wrb2fwd_i.rd_wr_req && (rs1_addr_i != '0) &&
                         (rs1_addr_i == wrb2fwd_i.rd_addr);
    assign rs2_wrb_hit = wrb2fwd_i.rd_wr_req && (rs2_addr_i != '0) &&
                         (rs2_addr_i == wrb2fwd_i.rd_addr);

    assign rs1_data_o = rs1_wrb_hit ? wrb_rd_data_i : rf_rs1_data_i;
    assign rs2_data_o = rs2_wrb_hit ? wrb_rd_data_i : rf_rs2_data_i;

    // Hold decode until the divide result is written
    assign rs1_div_hit = (rs1_addr_i != '0) && (rs1_addr_i == pipe2fwd_i.rd_addr);
    assign rs2_div_hit = (rs2_addr_i != '0) && (rs2_addr_i == pipe2fwd_i.rd_addr);
    assign fwd_stall_o = pipe2fwd_i.div_pending && (rs1_div_hit || rs2_div_hit);

endmodule : forward_stall

// ==== verilog/wrb_subsys.sv ====
/*
 * Back end of the RV32IM pipeline
 * LSU/writeback pipe, divider, writeback, register file and forward unit
 */

`timescale 1ns/1ps

module wrb_subsys import wrb_pkg::*; (
    input  logic          clk,
    input  logic          reset_i,

    // Completed instruction stream
    input  logic          in_valid_i,
    output logic          in_ready_o,
    input  lsu2wrb_data_s lsu2wrb_data_i,
    input  lsu2wrb_ctrl_s lsu2wrb_ctrl_i,
    input  csr2wrb_data_s csr2wrb_data_i,
    input  exe2div_s      exe2div_i,

    // Register write feedback
    output wrb2id_fb_s    wrb2id_fb_o,

    // Decode operand reads
    input  reg_addr_t     rs1_addr_i,
    input  reg_addr_t     rs2_addr_i,
    output data_t         rs1_data_o,
    output data_t         rs2_data_o,
    output logic          fwd_stall_o
);

    // Pipe to divider
    logic          div_start;
    exe2div_s      exe2div;
    logic          div_done;
    div2wrb_s      div2wrb;

    // Pipe to writeback and forward unit
    lsu2wrb_data_s pipe_data;
    lsu2wrb_ctrl_s pipe_ctrl;
    csr2wrb_data_s pipe_csr;
    pipe2fwd_s     pipe2fwd;

    // Writeback to forward unit
    data_t         wrb_rd_data;
    wrb2fwd_s      wrb2fwd;

    // Regfile to forward unit
    data_t         rf_rs1_data;
    data_t         rf_rs2_data;

    lsu_wrb_pipe u_pipe (
        .clk            (clk),
        .reset_i        (reset_i),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .lsu2wrb_data_i (lsu2wrb_data_i),
        .lsu2wrb_ctrl_i (lsu2wrb_ctrl_i),
        .csr2wrb_data_i (csr2wrb_data_i),
        .exe2div_i      (exe2div_i),
        .div_start_o    (div_start),
        .exe2div_o      (exe2div),
        .div_done_i     (div_done),
        .lsu2wrb_data_o (pipe_data),
        .lsu2wrb_ctrl_o (pipe_ctrl),
        .csr2wrb_data_o (pipe_csr),
        .pipe2fwd_o     (pipe2fwd)
    );

    divider u_div (
        .clk       (clk),
        .reset_i   (reset_i),
        .start_i   (div_start),
        .exe2div_i (exe2div),
        .done_o    (div_done),
        .div2wrb_o (div2wrb)
    );

    writeback u_wrb (
        .lsu2wrb_data_i       (pipe_data),
        .lsu2wrb_ctrl_i       (pipe_ctrl),
        .csr2wrb_data_i       (pipe_csr),
        .div2wrb_i            (div2wrb),
        .wrb2id_fb_o          (wrb2id_fb_o),
        .wrb2exe_fb_rd_data_o (wrb_rd_data),
        .wrb2fwd_o            (wrb2fwd)
    );

    regfile u_rf (
        .clk         (clk),
        .reset_i     (reset_i),
        .wrb2id_fb_i (wrb2id_fb_o),
        .rs1_addr_i  (rs1_addr_i),
        .rs2_addr_i  (rs2_addr_i),
        .rs1_data_o  (rf_rs1_data),
        .rs2_data_o  (rf_rs2_data)
    );

    forward_stall u_fwd (
        .rs1_addr_i    (rs1_addr_i),
        .rs2_addr_i    (rs2_addr_i),
        .rf_rs1_data_i (rf_rs1_data),
        .rf_rs2_data_i (rf_rs2_data),
        .wrb2fwd_i     (wrb2fwd),
        .wrb_rd_data_i (wrb_rd_data),
        .pipe2fwd_i    (pipe2fwd),
        .rs1_data_o    (rs1_data_o),
        .rs2_data_o    (rs2_data_o),
        .fwd_stall_o   (fwd_stall_o)
    );

endmodule : wrb_subsys

// ==== verification/tb_wrb_subsys.sv ====
/*
 * Directed testbench for the writeback subsystem
 * Checks commits against a model register file and a reference divide
 */

`timescale 1ns/1ps

module tb_wrb_subsys import wrb_pkg::*; ();

    // Upper bound on entries sent by all tests together
    localparam int N_ENTRIES  = 50;
    localparam int MAX_CYCLES = N_ENTRIES * (XLEN + 4) + 400;

    typedef struct packed {
        reg_addr_t rd;
        data_t     val;
    } commit_s;

    logic          clk;
    logic          reset_i;
    logic          in_valid_i;
    logic          in_ready_o;
    lsu2wrb_data_s lsu2wrb_data_i;
    lsu2wrb_ctrl_s lsu2wrb_ctrl_i;
    csr2wrb_data_s csr2wrb_data_i;
    exe2div_s      exe2div_i;
    wrb2id_fb_s    wrb2id_fb_o;
    reg_addr_t     rs1_addr_i;
    reg_addr_t     rs2_addr_i;
    data_t         rs1_data_o;
    data_t         rs2_data_o;
    logic          fwd_stall_o;

    // Expected commits in acceptance order and the architectural state
    commit_s       exp_q[$];
    data_t         model_rf [32];
    logic [31:0]   rng_state;
    string         test_name;
    int            mismatches;
    int            failures;
    int            cycles;
    int            commits;
    int            sent;

    wrb_subsys dut0 (
        .clk            (clk),
        .reset_i        (reset_i),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .lsu2wrb_data_i (lsu2wrb_data_i),
        .lsu2wrb_ctrl_i (lsu2wrb_ctrl_i),
        .csr2wrb_data_i (csr2wrb_data_i),
        .exe2div_i      (exe2div_i),
        .wrb2id_fb_o    (wrb2id_fb_o),
        .rs1_addr_i     (rs1_addr_i),
        .rs2_addr_i     (rs2_addr_i),
        .rs1_data_o     (rs1_data_o),
        .rs2_data_o     (rs2_data_o),
        .fwd_stall_o    (fwd_stall_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles during %s", cycles, test_name);
            $display("Errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_value(input string what, input data_t want, input data_t got);
        assert (got === want) else begin
            mismatches++;
            $display("MISMATCH %s %s: expected %h actual %h", test_name, what, want, got);
        end
    endtask

    // Commit monitor that also keeps the model register file current
    always @(posedge clk) begin
        commit_s head;
        if (!reset_i && wrb2id_fb_o.rd_wr_req) begin
            commits++;
            assert (exp_q.size() != 0) else begin
                failures++;
                $display("ERROR %s: commit to x%0d with no entry outstanding",
                         test_name, wrb2id_fb_o.rd_addr);
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                check_value("commit rd", data_t'(head.rd), data_t'(wrb2id_fb_o.rd_addr));
                check_value("commit data", head.val, wrb2id_fb_o.rd_data);
                if (head.rd != '0) begin
                    model_rf[head.rd] = head.val;
                end
            end
        end
    end

    // xorshift32
    function automatic logic [31:0] rand32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'(32'd1 + rand32() % 32'd31);
    endfunction

    function automatic reg_addr_t other_reg(input reg_addr_t r);
        return (r == 5'd31) ? 5'd1 : r + 5'd1;
    endfunction

    // Reference divide with the RISC-V M rules for zero divisor and overflow
    function automatic data_t ref_div(input div_op_e op, input data_t a, input data_t b);
        logic  ovf;
        data_t res;
        ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        case (op)
            DIV:     res = (b == '0) ? '1 : ovf ? a : data_t'($signed(a) / $signed(b));
            DIVU:    res = (b == '0) ? '1 : a / b;
            REM:     res = (b == '0) ? a : ovf ? '0 : data_t'($signed(a) % $signed(b));
            REMU:    res = (b == '0) ? a : a % b;
            default: res = '0;
        endcase
        return res;
    endfunction

    // Present one entry and hold it until the pipe takes it
    task automatic send_entry(input rd_wrb_sel_e sel, input lsu2wrb_data_s d,
                              input data_t csr, input exe2div_s e);
        commit_s entry;
        @(negedge clk);
        in_valid_i                = 1'b1;
        lsu2wrb_data_i            = d;
        lsu2wrb_ctrl_i.rd_wrb_sel = sel;
        lsu2wrb_ctrl_i.rd_wr_req  = 1'b1;
        csr2wrb_data_i.csr_rdata  = csr;
        exe2div_i                 = e;
        entry.rd = d.rd_addr;
        case (sel)
            RD_WRB_ALU:    entry.val = d.alu_result;
            RD_WRB_INC_PC: entry.val = d.pc_ff;
            RD_WRB_DMEM:   entry.val = d.r_data;
            RD_WRB_CSR:    entry.val = csr;
            RD_WRB_D_ALU:  entry.val = ref_div(e.op, e.dividend, e.divisor);
            default:       entry.val = '0;
        endcase
        exp_q.push_back(entry);
        sent++;
        @(posedge clk);
        while (!in_ready_o) begin
            @(posedge clk);
        end
    endtask

    task automatic send_plain(input rd_wrb_sel_e sel, input reg_addr_t rd);
        lsu2wrb_data_s d;
        exe2div_s      e;
        d.alu_result = rand32();
        d.pc_ff      = rand32();
        d.r_data     = rand32();
        d.rd_addr    = rd;
        e.op         = DIV;
        e.dividend   = rand32();
        e.divisor    = rand32();
        send_entry(sel, d, rand32(), e);
    endtask

    task automatic send_div(input div_op_e op, input reg_addr_t rd, input data_t a,
                            input data_t b);
        lsu2wrb_data_s d;
        exe2div_s      e;
        d.alu_result = rand32();
        d.pc_ff      = rand32();
        d.r_data     = rand32();
        d.rd_addr    = rd;
        e.op         = op;
        e.dividend   = a;
        e.divisor    = b;
        send_entry(RD_WRB_D_ALU, d, rand32(), e);
    endtask

    task automatic stop_input();
        @(negedge clk);
        in_valid_i = 1'b0;
    endtask

    // Wait until every accepted entry has committed
    task automatic drain();
        stop_input();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic check_reads(input reg_addr_t r1, input reg_addr_t r2);
        @(negedge clk);
        rs1_addr_i = r1;
        rs2_addr_i = r2;
        @(posedge clk);
        check_value($sformatf("read x%0d", r1), model_rf[r1], rs1_data_o);
        check_value($sformatf("read x%0d", r2), model_rf[r2], rs2_data_o);
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < 16; i++) begin
            check_reads(reg_addr_t'(i), reg_addr_t'(i + 16));
        end
    endtask

    task automatic probe_stall(input reg_addr_t r1, input reg_addr_t r2, input logic want);
        @(negedge clk);
        rs1_addr_i = r1;
        rs2_addr_i = r2;
        @(posedge clk);
        check_value($sformatf("stall rs1=x%0d rs2=x%0d", r1, r2), data_t'(want),
                    data_t'(fwd_stall_o));
    endtask

    task automatic test_select_paths();
        test_name = "select_paths";
        for (int i = 0; i < 3; i++) begin
            send_plain(RD_WRB_ALU, rand_reg());
            send_plain(RD_WRB_INC_PC, rand_reg());
            send_plain(RD_WRB_DMEM, rand_reg());
            send_plain(RD_WRB_CSR, rand_reg());
        end
        drain();
        check_all_regs();
    endtask

    task automatic test_x0();
        test_name = "x0";
        @(negedge clk);
        rs1_addr_i = '0;
        rs2_addr_i = '0;
        send_plain(RD_WRB_ALU, '0);
        send_plain(RD_WRB_DMEM, '0);
        stop_input();
        // A write to x0 is never bypassed to a read of x0
        @(posedge clk);
        check_value("x0 commit request", 32'd1, data_t'(wrb2id_fb_o.rd_wr_req));
        check_value("x0 rs1 during commit", '0, rs1_data_o);
        check_value("x0 rs2 during commit", '0, rs2_data_o);
        drain();
        check_reads('0, '0);
    endtask

    task automatic test_division();
        logic [31:0] r;
        data_t       b;
        test_name = "division";
        // Shifted divisors spread the quotient sizes
        for (int i = 0; i < 16; i++) begin
            r = rand32();
            b = rand32() >> (r % 32);
            if (r[5]) begin
                b = -b;
            end
            send_div(div_op_e'(r[9:8]), rand_reg(), rand32(), b);
        end
        send_div(DIV, rand_reg(), rand32(), '0);
        send_div(DIVU, rand_reg(), rand32(), '0);
        send_div(REM, rand_reg(), rand32(), '0);
        send_div(REMU, rand_reg(), rand32(), '0);
        send_div(DIV, rand_reg(), 32'h8000_0000, '1);
        send_div(REM, rand_reg(), 32'h8000_0000, '1);
        drain();
        check_all_regs();
    endtask

    task automatic expect_busy();
        @(negedge clk);
        check_value("in_ready during divide", '0, data_t'(in_ready_o));
    endtask

    task automatic test_order();
        int base;
        test_name = "order";
        base = commits;
        send_plain(RD_WRB_ALU, rand_reg());
        send_div(DIV, rand_reg(), rand32(), rand32());
        expect_busy();
        send_plain(RD_WRB_DMEM, rand_reg());
        send_plain(RD_WRB_INC_PC, rand_reg());
        send_div(REMU, rand_reg(), rand32(), rand32() >> 7);
        expect_busy();
        send_plain(RD_WRB_CSR, rand_reg());
        drain();
        check_value("commit count", 32'd6, data_t'(commits - base));
    endtask

    task automatic test_bypass();
        reg_addr_t     r;
        reg_addr_t     o;
        data_t         old_val;
        lsu2wrb_data_s d;
        exe2div_s      e;
        test_name = "bypass";
        r       = rand_reg();
        o       = other_reg(r);
        old_val = model_rf[r];
        @(negedge clk);
        rs1_addr_i   = r;
        rs2_addr_i   = o;
        d.alu_result = ~old_val;
        d.pc_ff      = rand32();
        d.r_data     = rand32();
        d.rd_addr    = r;
        e            = '0;
        send_entry(RD_WRB_ALU, d, rand32(), e);
        stop_input();
        // In the commit cycle the register file still holds the old value
        @(posedge clk);
        check_value("commit request", 32'd1, data_t'(wrb2id_fb_o.rd_wr_req));
        check_value("regfile before write", old_val, dut0.rf_rs1_data);
        check_value("rs1 bypass", ~old_val, rs1_data_o);
        check_value("rs2 no bypass", model_rf[o], rs2_data_o);
        drain();
        check_reads(r, o);
    endtask

    task automatic test_stall();
        reg_addr_t r;
        reg_addr_t o;
        test_name = "stall";
        r = rand_reg();
        o = other_reg(r);
        send_div(DIVU, r, rand32(), rand32() | 32'd1);
        stop_input();
        probe_stall(r, o, 1'b1);
        probe_stall(o, r, 1'b1);
        probe_stall(o, o, 1'b0);
        probe_stall('0, '0, 1'b0);
        probe_stall(r, '0, 1'b1);
        @(posedge clk);
        while (!wrb2id_fb_o.rd_wr_req) begin
            @(posedge clk);
        end
        // Still pending in the commit cycle and clear one cycle later
        check_value("stall in commit cycle", 32'd1, data_t'(fwd_stall_o));
        @(posedge clk);
        check_value("stall after commit", '0, data_t'(fwd_stall_o));
        drain();
        // A divide to x0 holds back no read of x0
        send_div(DIV, '0, rand32(), rand32());
        stop_input();
        probe_stall('0, '0, 1'b0);
        drain();
    endtask

    initial begin
        rng_state      = 32'd38;
        mismatches     = 0;
        failures       = 0;
        cycles         = 0;
        commits        = 0;
        sent           = 0;
        test_name      = "reset";
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        reset_i        = 1'b1;
        in_valid_i     = 1'b0;
        lsu2wrb_data_i = '0;
        lsu2wrb_ctrl_i = '0;
        csr2wrb_data_i = '0;
        exe2div_i      = '0;
        rs1_addr_i     = '0;
        rs2_addr_i     = '0;
        repeat (2) @(posedge clk);
        check_value("in_ready during reset", '0, data_t'(in_ready_o));
        @(negedge clk);
        reset_i = 1'b0;
        check_value("write request after reset", '0, data_t'(wrb2id_fb_o.rd_wr_req));
        check_value("stall after reset", '0, data_t'(fwd_stall_o));

        test_select_paths();
        test_x0();
        test_division();
        test_order();
        test_bypass();
        test_stall();

        test_name = "end";
        assert ((commits == sent) && (exp_q.size() == 0)) else begin
            failures++;
            $display("ERROR: %0d entries sent but %0d committed", sent, commits);
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if ((mismatches + failures) == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tb_wrb_subsys

// ==== compile.f ====
verilog/wrb_pkg.sv
verilog/lsu_wrb_pipe.sv
verilog/divider.sv
verilog/writeback.sv
verilog/regfile.sv
verilog/forward_stall.sv
verilog/wrb_subsys.sv
verification/tb_wrb_subsys.sv

// ==== Makefile ====
# Verilator build and run for the writeback subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_wrb_subsys
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
